// File: all.f
common/wb_pkg.sv
common/tile_pkg.sv
hw/bus/wb_arbiter.sv
hw/bus/wb_addr_decode.sv
hw/slaves/wb_sram.sv
hw/slaves/wb_ctrl_regs.sv
hw/tile_bus_top.sv
tb/tb_tile_bus.sv

// File: tb/tb_tile_bus.sv
/* Tile bus testbench */

`timescale 1ns/1ns

module tb_tile_bus;

   localparam int TIMEOUT = 50;
   localparam wb_pkg::dat_t ID_WORD = 32'h7C1E_0001;

   logic               clk;
   logic               rst_n;
   wb_pkg::wb_req_t    m0_req;
   wb_pkg::wb_req_t    m1_req;
   wb_pkg::wb_rsp_t    m0_rsp;
   wb_pkg::wb_rsp_t    m1_rsp;
   // Reference model.
   wb_pkg::dat_t       sram_img [tile_pkg::SRAM_DEPTH];
   wb_pkg::dat_t       scratch_img;
   // Expected read data per master.
   logic [1:0]         chk_on;
   wb_pkg::dat_t [1:0] chk_dat;
   logic [31:0]        rng;
   int unsigned        cyc_n;
   int                 errors;
   int                 n_pass;
   int                 n_fail;

   tile_bus_top uut (
      .clk_i    (clk),
      .rst_n_i  (rst_n),
      .m0_req_i (m0_req),
      .m0_rsp_o (m0_rsp),
      .m1_req_i (m1_req),
      .m1_rsp_o (m1_rsp)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // Cycle count for ack timestamps.
   always @(posedge clk) cyc_n <= cyc_n + 1;

   task automatic log_mismatch(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
      $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
      errors++;
   endtask

   task automatic note_failure(input string what);
      $display("Error: %s", what);
      errors++;
   endtask

   // Read data against the model.
   a_m0_data: assert property (@(posedge clk) disable iff (!rst_n)
      (m0_rsp.ack && chk_on[0]) |-> (m0_rsp.dat == chk_dat[0]))
      else log_mismatch("m0_rsp_o.dat", $sampled(m0_rsp.dat), $sampled(chk_dat[0]));
   a_m1_data: assert property (@(posedge clk) disable iff (!rst_n)
      (m1_rsp.ack && chk_on[1]) |-> (m1_rsp.dat == chk_dat[1]))
      else log_mismatch("m1_rsp_o.dat", $sampled(m1_rsp.dat), $sampled(chk_dat[1]));
   a_one_ack: assert property (@(posedge clk) disable iff (!rst_n)
      !(m0_rsp.ack && m1_rsp.ack))
      else note_failure("both masters received ack in the same cycle");

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x ^= x << 13;
      x ^= x >> 17;
      x ^= x << 5;
      return x;
   endfunction

   // Set lanes take the new byte.
   function automatic wb_pkg::dat_t merge_bytes(input wb_pkg::dat_t old_w,
                                                input wb_pkg::dat_t new_w,
                                                input wb_pkg::sel_t sel);
      wb_pkg::dat_t w;
      int i;
      w = old_w;
      for (i = 0; i < 4; i++) begin
         if (sel[i]) w[8*i +: 8] = new_w[8*i +: 8];
      end
      return w;
   endfunction

   task automatic drive_req(input int m, input wb_pkg::wb_req_t req);
      if (m == 0) m0_req = req;
      else m1_req = req;
   endtask

   // One classic cycle.
   // lat counts cycles from stb to ack or err.
   task automatic bus_cycle(input int m, input wb_pkg::adr_t adr, input wb_pkg::dat_t dat,
                            input wb_pkg::sel_t sel, input logic we, input logic chk,
                            input wb_pkg::dat_t exp, output wb_pkg::wb_rsp_t rsp,
                            output int lat, output int unsigned ack_at);
      wb_pkg::wb_req_t req;
      int n;
      req = '{adr: adr, dat: dat, sel: sel, we: we, cyc: 1'b1, stb: 1'b1};
      chk_on[m] = chk;
      chk_dat[m] = exp;
      drive_req(m, req);
      n = 0;
      rsp = '0;
      while (!(rsp.ack || rsp.err) && n < TIMEOUT) begin
         @(negedge clk);
         n++;
         rsp = (m == 0) ? m0_rsp : m1_rsp;
      end
      if (!(rsp.ack || rsp.err)) note_failure($sformatf("master %0d got no ack or err", m));
      // First negedge falls in the stb cycle itself.
      lat = n - 1;
      ack_at = cyc_n;
      @(posedge clk);
      #1;
      chk_on[m] = 1'b0;
      drive_req(m, '0);
      // One idle cycle so the arbiter returns to idle.
      @(posedge clk);
      #1;
   endtask

   task automatic end_test(input string name, input int start_errs);
      if (errors == start_errs) begin
         n_pass++;
         $display("[ok]   %s", name);
      end else begin
         n_fail++;
         $display("[FAIL] %s", name);
      end
   endtask

   initial begin
      wb_pkg::wb_rsp_t     rsp;
      wb_pkg::wb_rsp_t     rsp1;
      int                  lat;
      int                  lat1;
      int unsigned         t0;
      int unsigned         t1;
      wb_pkg::adr_t        adr;
      wb_pkg::dat_t        c1;
      wb_pkg::sel_t        sel;
      tile_pkg::sram_idx_t idx;
      int                  k;
      int                  e;
      int                  win;
      m0_req = '0;
      m1_req = '0;
      rst_n = 1'b0;
      chk_on = '0;
      chk_dat = '0;
      rng = 32'd20;
      cyc_n = 0;
      errors = 0;
      n_pass = 0;
      n_fail = 0;
      repeat (8) @(posedge clk);
      #1;
      rst_n = 1'b1;
      @(posedge clk);
      #1;

      // Full write and partial write, then a read by the other master.
      e = errors;
      for (k = 0; k < 8; k++) begin
         rng = xorshift(rng);
         idx = rng[7:0];
         adr = {1'b0, rng[30:10], idx, 2'b00};
         rng = xorshift(rng);
         sram_img[idx] = rng;
         bus_cycle(k % 2, adr, rng, 4'hF, 1'b1, 1'b0, '0, rsp, lat, t0);
         rng = xorshift(rng);
         sel = rng[3:0];
         rng = xorshift(rng);
         sram_img[idx] = merge_bytes(sram_img[idx], rng, sel);
         bus_cycle(k % 2, adr, rng, sel, 1'b1, 1'b0, '0, rsp, lat, t0);
         bus_cycle((k + 1) % 2, adr, '0, 4'hF, 1'b0, 1'b1, sram_img[idx], rsp, lat, t0);
      end
      end_test("sram read-back", e);

      // Unmapped region.
      e = errors;
      bus_cycle(0, 32'h8000_0000, '0, 4'hF, 1'b0, 1'b0, '0, rsp, lat, t0);
      assert (rsp.err && !rsp.ack) else note_failure("unmapped access did not end with err only");
      assert (rsp.dat == '0) else log_mismatch("m0_rsp_o.dat", rsp.dat, 32'h0);
      assert (lat == 1) else log_mismatch("err latency", lat, 1);
      end_test("error response", e);

      // ID ignores writes.
      // Scratch merges by lane.
      e = errors;
      bus_cycle(1, 32'hE000_0000, '0, 4'hF, 1'b0, 1'b1, ID_WORD, rsp, lat, t0);
      bus_cycle(0, 32'hE000_0000, 32'hFFFF_FFFF, 4'hF, 1'b1, 1'b0, '0, rsp, lat, t0);
      bus_cycle(1, 32'hE000_0000, '0, 4'hF, 1'b0, 1'b1, ID_WORD, rsp, lat, t0);
      rng = xorshift(rng);
      scratch_img = rng;
      bus_cycle(0, 32'hE000_0004, rng, 4'hF, 1'b1, 1'b0, '0, rsp, lat, t0);
      rng = xorshift(rng);
      scratch_img = merge_bytes(scratch_img, rng, 4'b0101);
      bus_cycle(1, 32'hE000_0004, rng, 4'b0101, 1'b1, 1'b0, '0, rsp, lat, t0);
      bus_cycle(0, 32'hE000_0004, '0, 4'hF, 1'b0, 1'b1, scratch_img, rsp, lat, t0);
      end_test("id and scratch registers", e);

      // Counter advances at least as far as the acks.
      e = errors;
      bus_cycle(0, 32'hE000_0008, '0, 4'hF, 1'b0, 1'b0, '0, rsp, lat, t0);
      c1 = rsp.dat;
      repeat (12) @(posedge clk);
      #1;
      bus_cycle(1, 32'hE000_0008, '0, 4'hF, 1'b0, 1'b0, '0, rsp, lat, t1);
      assert (rsp.dat > c1) else log_mismatch("m1_rsp_o.dat", rsp.dat, c1 + 1);
      assert (rsp.dat - c1 >= t1 - t0) else log_mismatch("counter step", rsp.dat - c1, t1 - t0);
      end_test("cycle counter", e);

      // Tie wins alternate and start with master 0.
      e = errors;
      for (k = 0; k < 4; k++) begin
         fork
            bus_cycle(0, 32'hE000_0000, '0, 4'hF, 1'b0, 1'b1, ID_WORD, rsp, lat, t0);
            bus_cycle(1, 32'hE000_0004, '0, 4'hF, 1'b0, 1'b1, scratch_img, rsp1, lat1, t1);
         join
         assert (rsp.ack && rsp1.ack) else note_failure("a contending request did not complete");
         win = (t0 < t1) ? 0 : 1;
         assert (win == k % 2) else log_mismatch("tie winner", win, k % 2);
         // Lone access by the winner, so the next tie goes the other way.
         bus_cycle(win, 32'hE000_0000, '0, 4'hF, 1'b0, 1'b1, ID_WORD, rsp, lat, t0);
      end
      end_test("arbitration under contention", e);

      // Lone request on an idle bus acks two cycles after stb.
      e = errors;
      adr = {22'h0, idx, 2'b00};
      bus_cycle(0, adr, '0, 4'hF, 1'b0, 1'b1, sram_img[idx], rsp, lat, t0);
      assert (lat == 2) else log_mismatch("m0 ack latency", lat, 2);
      bus_cycle(1, adr, '0, 4'hF, 1'b0, 1'b1, sram_img[idx], rsp, lat, t0);
      assert (lat == 2) else log_mismatch("m1 ack latency", lat, 2);
      end_test("idle-bus latency", e);

      $display("Tests: %0d passed, %0d failed", n_pass, n_fail);
      if (errors == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

// File: hw/tile_bus_top.sv
/* Two-master bus tile */

`timescale 1ns/1ns

module tile_bus_top (
   input  logic            clk_i,
   input  logic            rst_n_i,
   input  wb_pkg::wb_req_t m0_req_i,
   output wb_pkg::wb_rsp_t m0_rsp_o,
   input  wb_pkg::wb_req_t m1_req_i,
   output wb_pkg::wb_rsp_t m1_rsp_o
);

   // Shared bus after arbitration.
   wb_pkg::wb_req_t bus_req;
   wb_pkg::wb_rsp_t bus_rsp;
   // Per-slave links.
   wb_pkg::wb_req_t sram_req;
   wb_pkg::wb_rsp_t sram_rsp;
   wb_pkg::wb_req_t ctrl_req;
   wb_pkg::wb_rsp_t ctrl_rsp;

   wb_arbiter u_arb (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .m0_req_i  (m0_req_i),
      .m1_req_i  (m1_req_i),
      .m0_rsp_o  (m0_rsp_o),
      .m1_rsp_o  (m1_rsp_o),
      .bus_req_o (bus_req),
      .bus_rsp_i (bus_rsp)
   );

   wb_addr_decode u_dec (
      .bus_req_i  (bus_req),
      .bus_rsp_o  (bus_rsp),
      .sram_req_o (sram_req),
      .sram_rsp_i (sram_rsp),
      .ctrl_req_o (ctrl_req),
      .ctrl_rsp_i (ctrl_rsp)
   );

   // Slave 0.
   wb_sram u_sram (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .req_i   (sram_req),
      .rsp_o   (sram_rsp)
   );

   // Slave 1.
   wb_ctrl_regs u_ctrl (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .req_i   (ctrl_req),
      .rsp_o   (ctrl_rsp)
   );

endmodule

// File: hw/slaves/wb_ctrl_regs.sv
/* Control register slave */

`timescale 1ns/1ns

module wb_ctrl_regs (
   input  logic            clk_i,
   input  logic            rst_n_i,
   input  wb_pkg::wb_req_t req_i,
   output wb_pkg::wb_rsp_t rsp_o
);

   wb_pkg::dat_t scratch_q;
   wb_pkg::dat_t cnt_q;
   wb_pkg::dat_t rd_data;
   wb_pkg::dat_t rdat_q;
   logic         ack_q;
   logic         acc;
   logic [1:0]   ofs;

   // Register select, bits 3..2.
   assign ofs = req_i.adr[3:2];

   // Same ack rule as the SRAM.
   assign acc = req_i.cyc & req_i.stb & ~ack_q;

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         ack_q     <= 1'b0;
         scratch_q <= '0;
         cnt_q     <= '0;
      end else begin
         ack_q <= acc;
         // Free-running cycle counter.
         cnt_q <= cnt_q + 1'b1;
         // Scratch is the only writable register.
         if (acc && req_i.we && ofs == tile_pkg::CTRL_SCRATCH_OFS[3:2]) begin
            for (int i = 0; i < wb_pkg::SEL_W; i++) begin
               if (req_i.sel[i]) scratch_q[8*i +: 8] <= req_i.dat[8*i +: 8];
            end
         end
      end
   end

   // Read mux.
   // Unused offsets read zero.
   always_comb begin
      case (ofs)
         tile_pkg::CTRL_ID_OFS[3:2]:      rd_data = tile_pkg::CTRL_ID_VALUE;
         tile_pkg::CTRL_SCRATCH_OFS[3:2]: rd_data = scratch_q;
         tile_pkg::CTRL_CNT_OFS[3:2]:     rd_data = cnt_q;
         default:                         rd_data = '0;
      endcase
   end

   // Capture read data on the strobe.
   always_ff @(posedge clk_i) begin
      if (acc) begin
         rdat_q <= rd_data;
      end
   end

   assign rsp_o.dat = rdat_q;
   assign rsp_o.ack = ack_q;
   assign rsp_o.err = 1'b0;

endmodule

// File: hw/slaves/wb_sram.sv
/* Wishbone SRAM slave */

`timescale 1ns/1ns

module wb_sram (
   input  logic            clk_i,
   input  logic            rst_n_i,
   input  wb_pkg::wb_req_t req_i,
   output wb_pkg::wb_rsp_t rsp_o
);

   wb_pkg::dat_t       mem [tile_pkg::SRAM_DEPTH];
   tile_pkg::sram_idx_t idx;
   wb_pkg::dat_t       rdat_q;
   logic               ack_q;
   logic               acc;

   // Word index from address bits 9..2.
   assign idx = req_i.adr[9:2];

   // New access only when not acking already.
   assign acc = req_i.cyc & req_i.stb & ~ack_q;

   // Ack one cycle after strobe.
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= acc;
      end
   end

   // Byte lane writes.
   always_ff @(posedge clk_i) begin
      if (acc && req_i.we) begin
         for (int i = 0; i < wb_pkg::SEL_W; i++) begin
            if (req_i.sel[i]) mem[idx][8*i +: 8] <= req_i.dat[8*i +: 8];
         end
      end
   end

   // Read data, valid with ack.
   always_ff @(posedge clk_i) begin
      if (acc) begin
         rdat_q <= mem[idx];
      end
   end

   assign rsp_o.dat = rdat_q;
   assign rsp_o.ack = ack_q;
   assign rsp_o.err = 1'b0;

   // Single-cycle ack only.
   a_no_double_ack: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      ack_q |=> !ack_q);

endmodule

// File: hw/bus/wb_addr_decode.sv
/* Wishbone address decoder */

`timescale 1ns/1ns

module wb_addr_decode (
   input  wb_pkg::wb_req_t bus_req_i,
   output wb_pkg::wb_rsp_t bus_rsp_o,
   output wb_pkg::wb_req_t sram_req_o,
   input  wb_pkg::wb_rsp_t sram_rsp_i,
   output wb_pkg::wb_req_t ctrl_req_o,
   input  wb_pkg::wb_rsp_t ctrl_rsp_i
);

   logic sram_sel;
   logic ctrl_sel;

   // Region match on the upper address bits.
   assign sram_sel = (bus_req_i.adr[31] == tile_pkg::SRAM_MATCH);
   assign ctrl_sel = (bus_req_i.adr[31:28] == tile_pkg::CTRL_MATCH);

   // Both slaves see the bus.
   // Only the selected one gets stb.
   always_comb begin
      sram_req_o     = bus_req_i;
      sram_req_o.stb = bus_req_i.stb & sram_sel;
      ctrl_req_o     = bus_req_i;
      ctrl_req_o.stb = bus_req_i.stb & ctrl_sel;
   end

   // Response mux.
   always_comb begin
      if (sram_sel) begin
         bus_rsp_o = sram_rsp_i;
      end else if (ctrl_sel) begin
         bus_rsp_o = ctrl_rsp_i;
      end else begin
         // Unmapped address.
         // Error right away, no data.
         bus_rsp_o.dat = '0;
         bus_rsp_o.ack = 1'b0;
         bus_rsp_o.err = bus_req_i.cyc & bus_req_i.stb;
      end
   end

   // Never strobe both slaves at once.
   always_comb begin
      a_one_stb: assert final (!(sram_req_o.stb && ctrl_req_o.stb));
   end

endmodule

// File: hw/bus/wb_arbiter.sv
/* Round-robin bus arbiter */

`timescale 1ns/1ns

module wb_arbiter (
   input  logic            clk_i,
   input  logic            rst_n_i,
   input  wb_pkg::wb_req_t m0_req_i,
   input  wb_pkg::wb_req_t m1_req_i,
   output wb_pkg::wb_rsp_t m0_rsp_o,
   output wb_pkg::wb_rsp_t m1_rsp_o,
   output wb_pkg::wb_req_t bus_req_o,
   input  wb_pkg::wb_rsp_t bus_rsp_i
);

   wb_pkg::arb_state_t state_q;
   wb_pkg::arb_state_t state_d;
   // Set when master 1 won the last grant.
   logic               last_q;
   logic               last_d;

   // Grant FSM.
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         state_q <= wb_pkg::ARB_IDLE;
         // Pretend master 1 won, so master 0 takes the first tie.
         last_q  <= 1'b1;
      end else begin
         state_q <= state_d;
         last_q  <= last_d;
      end
   end

   always_comb begin
      state_d = state_q;
      last_d  = last_q;
      case (state_q)
         wb_pkg::ARB_IDLE: begin
            // Tie goes to the master that lost last time.
            if (m0_req_i.cyc && m1_req_i.cyc) begin
               state_d = last_q ? wb_pkg::ARB_M0 : wb_pkg::ARB_M1;
               last_d  = ~last_q;
            end else if (m0_req_i.cyc) begin
               state_d = wb_pkg::ARB_M0;
               last_d  = 1'b0;
            end else if (m1_req_i.cyc) begin
               state_d = wb_pkg::ARB_M1;
               last_d  = 1'b1;
            end
         end
         // Hold the grant for the whole cycle.
         wb_pkg::ARB_M0: begin
            if (!m0_req_i.cyc) state_d = wb_pkg::ARB_IDLE;
         end
         wb_pkg::ARB_M1: begin
            if (!m1_req_i.cyc) state_d = wb_pkg::ARB_IDLE;
         end
         default: state_d = wb_pkg::ARB_IDLE;
      endcase
   end

   // Bus mux and response routing.
   // The loser sees zeros.
   always_comb begin
      bus_req_o = '0;
      m0_rsp_o  = '0;
      m1_rsp_o  = '0;
      case (state_q)
         wb_pkg::ARB_M0: begin
            bus_req_o = m0_req_i;
            m0_rsp_o  = bus_rsp_i;
         end
         wb_pkg::ARB_M1: begin
            bus_req_o = m1_req_i;
            m1_rsp_o  = bus_rsp_i;
         end
         default: bus_req_o = '0;
      endcase
   end

   // Only one master may be acknowledged per cycle.
   a_one_ack: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      !(m0_rsp_o.ack && m1_rsp_o.ack));

endmodule

// File: common/tile_pkg.sv
/* Tile address map */

package tile_pkg;

   // Slave 0 when bit 31 is clear.
   localparam logic SRAM_MATCH = 1'b0;
   // Slave 1 when bits 31..28 are hex E.
   localparam logic [3:0] CTRL_MATCH = 4'hE;

   // SRAM size in words.
   localparam int SRAM_DEPTH = 256;
   localparam int SRAM_IDX_W = $clog2(SRAM_DEPTH);

   // Word index, taken from address bits 9..2.
   typedef logic [SRAM_IDX_W-1:0] sram_idx_t;

   // Control register byte offsets.
   typedef logic [3:0] ctrl_ofs_t;

   localparam ctrl_ofs_t CTRL_ID_OFS      = 4'h0;
   localparam ctrl_ofs_t CTRL_SCRATCH_OFS = 4'h4;
   localparam ctrl_ofs_t CTRL_CNT_OFS     = 4'h8;

   // Fixed ID word.
   localparam wb_pkg::dat_t CTRL_ID_VALUE = 32'h7C1E_0001;

endpackage

// File: common/wb_pkg.sv
/* Wishbone bus types */

package wb_pkg;

   // Bus widths.
   localparam int ADR_W = 32;
   localparam int DAT_W = 32;
   localparam int SEL_W = DAT_W / 8;

   // Byte address.
   typedef logic [ADR_W-1:0] adr_t;
   // Data word.
   typedef logic [DAT_W-1:0] dat_t;
   // One select bit per byte lane.
   typedef logic [SEL_W-1:0] sel_t;

   // Master to slave direction.
   // Classic single cycles only, so no cti or bte.
   typedef struct packed {
      adr_t adr;
      dat_t dat;
      sel_t sel;
      logic we;
      logic cyc;
      logic stb;
   } wb_req_t;

   // Slave to master direction.
   // No retry line.
   typedef struct packed {
      dat_t dat;
      logic ack;
      logic err;
   } wb_rsp_t;

   // Arbiter grant state.
   typedef enum logic [1:0] {
      ARB_IDLE = 2'd0,
      ARB_M0   = 2'd1,
      ARB_M1   = 2'd2
   } arb_state_t;

endpackage
